/* list.f */
source/cache_pkg.sv
source/cache_ctrl_if.sv
source/meta_array.sv
source/line_array.sv
source/cache_datapath.sv
source/cache_control.sv
source/l1_cache.sv
sim/clock_gen.sv
sim/cache_checker.sv
sim/cache_properties.sv
sim/tb_l1_cache.sv

/* sim/cache_stimulus.txt */
// op(0 read, 1 write, 2 end) address byte_enable data expected_word fills write_backs
// Expected word is the word at the address offset; it is ignored for writes.
0 00000000 00000000 00000000 00000000 1 0
0 00000004 00000000 00000000 00000004 0 0
1 00000008 00000300 aabbccdd 00000000 0 0
0 00000008 00000000 00000000 0000ccdd 0 0
0 00000100 00000000 00000000 00000100 1 0
0 00000000 00000000 00000000 00000000 0 0
0 00000104 00000000 00000000 00000104 0 0
0 00000200 00000000 00000000 00000200 1 1
0 00000000 00000000 00000000 00000000 1 0
0 00000008 00000000 00000000 0000ccdd 0 0
1 00000020 ffffffff 12345678 00000000 1 0
0 0000003c 00000000 00000000 12345678 0 0
0 00000120 00000000 00000000 00000120 1 0
0 00000220 00000000 00000000 00000220 1 1
0 00000024 00000000 00000000 12345678 1 0
1 00000044 000000f0 deadbeef 00000000 1 0
0 00000044 00000000 00000000 deadbeef 0 0
0 00000040 00000000 00000000 00000040 0 0
1 00000210 000f0000 55aa55aa 00000000 0 0
0 00000100 00000000 00000000 00000100 1 0
0 00000300 00000000 00000000 00000300 1 1
0 00000210 00000000 00000000 55aa55aa 1 0
0 00000214 00000000 00000000 00000214 0 0
2 00000000 00000000 00000000 00000000 0 0

/* sim/tb_l1_cache.sv */
// Testbench top with DUT, memory model, file stimulus, timeout and final report.
`timescale 1ns/10ps

module tb_l1_cache;
    import cache_pkg::*;

    localparam real clk_period   = 4.0;
    localparam int  reset_cycles = 8;
    localparam int  cycles_per_op = 40;
    localparam int  max_ops      = 64;

    logic        clk;
    logic        rst_n;
    addr_t       mem_address;
    logic        mem_read;
    logic        mem_write;
    byte_en_t    mem_byte_enable256;
    line_t       mem_wdata256;
    line_t       mem_rdata256;
    logic        mem_resp;
    addr_t       pmem_address;
    logic        pmem_read;
    logic        pmem_write;
    line_t       pmem_wdata;
    line_t       pmem_rdata;
    logic        pmem_resp;
    logic [31:0] exp_word;
    logic [31:0] exp_fills;
    logic [31:0] exp_wbs;
    logic [31:0] stim [7*max_ops];
    line_t       memory [logic [26:0]];
    int          num_ops;
    int          cycle_count;
    int          timeout_limit;
    int          mem_wait;
    logic        mem_busy;
    int          checker_errors;
    int          assert_errors;

    clock_gen #(.period(clk_period), .reset_cycles(reset_cycles)) u_clock
    (
        .clk   (clk),
        .rst_n (rst_n)
    );

    l1_cache l1_cache_i
    (
        .clk (clk), .rst_n (rst_n),
        .mem_address (mem_address), .mem_read (mem_read), .mem_write (mem_write),
        .mem_byte_enable256 (mem_byte_enable256), .mem_wdata256 (mem_wdata256),
        .mem_rdata256 (mem_rdata256), .mem_resp (mem_resp),
        .pmem_address (pmem_address), .pmem_read (pmem_read), .pmem_write (pmem_write),
        .pmem_wdata (pmem_wdata), .pmem_rdata (pmem_rdata), .pmem_resp (pmem_resp)
    );

    cache_checker u_checker
    (
        .clk (clk), .rst_n (rst_n),
        .mem_address (mem_address), .mem_read (mem_read), .mem_write (mem_write),
        .mem_byte_enable256 (mem_byte_enable256), .mem_wdata256 (mem_wdata256),
        .mem_rdata256 (mem_rdata256), .mem_resp (mem_resp),
        .pmem_address (pmem_address), .pmem_read (pmem_read), .pmem_write (pmem_write),
        .pmem_wdata (pmem_wdata), .pmem_resp (pmem_resp),
        .exp_word (exp_word), .exp_fills (exp_fills), .exp_wbs (exp_wbs),
        .error_count (checker_errors)
    );

    assign assert_errors = l1_cache_i.u_properties.assert_failures;

    function automatic line_t memory_line(input logic [26:0] line_addr);
        line_t l;
        if (memory.exists(line_addr))
            return memory[line_addr];
        for (int i = 0; i < 8; i++)
            l[32*i +: 32] = {line_addr, 5'b0} + 32'(4 * i);
        return l;
    endfunction

    // Memory answers each request after 3 to 6 cycles.
    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            pmem_resp <= 1'b0;
            mem_busy  <= 1'b0;
        end
        else if (pmem_resp)
        begin
            pmem_resp <= 1'b0;
            mem_busy  <= 1'b0;
        end
        else if (pmem_read || pmem_write)
        begin
            if (!mem_busy)
            begin
                mem_busy <= 1'b1;
                mem_wait <= 3 + ($urandom % 4);
            end
            else if (mem_wait <= 1)
            begin
                pmem_resp <= 1'b1;
                if (pmem_write)
                    memory[pmem_address[31:5]] = pmem_wdata;
                else
                    pmem_rdata <= memory_line(pmem_address[31:5]);
            end
            else
                mem_wait <= mem_wait - 1;
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= timeout_limit)
        begin
            $display("Timeout after %0d cycles, the cache stopped responding", cycle_count);
            $display("Finished with errors");
            $display("Operations %0d, check errors %0d, assertion failures %0d",
                     num_ops, checker_errors, assert_errors);
            $finish;
        end
    end

    initial
    begin
        mem_address <= '0;
        mem_read <= 1'b0;
        mem_write <= 1'b0;
        mem_byte_enable256 <= '0;
        mem_wdata256 <= '0;
        pmem_rdata <= '0;
        pmem_resp <= 1'b0;
        mem_busy <= 1'b0;
        mem_wait <= 0;
        exp_word <= '0;
        exp_fills <= '0;
        exp_wbs <= '0;
        cycle_count = 0;
        void'($urandom(32'ha087_e781));
        $readmemh("sim/cache_stimulus.txt", stim);
        num_ops = 0;
        while (num_ops < max_ops && stim[7*num_ops] !== 32'h2 && stim[7*num_ops] !== 'x)
            num_ops++;
        timeout_limit = num_ops * cycles_per_op + reset_cycles;

        wait (rst_n === 1'b1);
        for (int k = 0; k < num_ops; k++)
        begin
            @(posedge clk);
            mem_read           <= (stim[7*k] == 32'h0);
            mem_write          <= (stim[7*k] == 32'h1);
            mem_address        <= stim[7*k+1];
            mem_byte_enable256 <= stim[7*k+2];
            mem_wdata256       <= {8{stim[7*k+3]}};
            exp_word           <= stim[7*k+4];
            exp_fills          <= stim[7*k+5];
            exp_wbs            <= stim[7*k+6];
            do
                @(posedge clk);
            while (!mem_resp);
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
        end
        repeat (2) @(posedge clk);

        if (num_ops == 0)
            $display("No operations were read from the stimulus file");
        if (checker_errors == 0 && assert_errors == 0 && num_ops > 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $display("Operations %0d, check errors %0d, assertion failures %0d",
                 num_ops, checker_errors, assert_errors);
        $finish;
    end

endmodule : tb_l1_cache

/* sim/cache_properties.sv */
// Concurrent assertions on the processor and memory handshakes of the cache.
`timescale 1ns/10ps

module cache_properties
(
    input logic             clk,
    input logic             rst_n,
    input logic             mem_resp,
    input logic             pmem_read,
    input logic             pmem_write,
    input logic             pmem_resp,
    input cache_pkg::addr_t pmem_address
);

    int assert_failures;

    initial
        assert_failures = 0;

    resp_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        mem_resp |=> !mem_resp)
        else
        begin
            assert_failures++;
            $error("mem_resp held longer than one cycle");
        end

    read_write_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(pmem_read && pmem_write))
        else
        begin
            assert_failures++;
            $error("pmem_read and pmem_write high together");
        end

    // Address must not move until the memory answers.
    address_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ((pmem_read || pmem_write) && !pmem_resp) |=> $stable(pmem_address))
        else
        begin
            assert_failures++;
            $error("pmem_address changed during a pending request");
        end

endmodule : cache_properties

bind l1_cache cache_properties u_properties
(
    .clk          (clk),
    .rst_n        (rst_n),
    .mem_resp     (mem_resp),
    .pmem_read    (pmem_read),
    .pmem_write   (pmem_write),
    .pmem_resp    (pmem_resp),
    .pmem_address (pmem_address)
);

/* sim/cache_checker.sv */
// Shadow memory, read data, transfer count, hit latency and write-back data checks.
`timescale 1ns/10ps

module cache_checker
(
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::addr_t    mem_address,
    input  logic                mem_read,
    input  logic                mem_write,
    input  cache_pkg::byte_en_t mem_byte_enable256,
    input  cache_pkg::line_t    mem_wdata256,
    input  cache_pkg::line_t    mem_rdata256,
    input  logic                mem_resp,
    input  cache_pkg::addr_t    pmem_address,
    input  logic                pmem_read,
    input  logic                pmem_write,
    input  cache_pkg::line_t    pmem_wdata,
    input  logic                pmem_resp,
    input  logic [31:0]         exp_word,
    input  logic [31:0]         exp_fills,
    input  logic [31:0]         exp_wbs,
    output int                  error_count
);
    import cache_pkg::*;

    line_t shadow [logic [26:0]];
    int    fills;
    int    wbs;
    int    cycles;

    // Each word of memory initially holds its own byte address.
    function automatic line_t initial_line(input logic [26:0] line_addr);
        line_t l;
        for (int i = 0; i < 8; i++)
            l[32*i +: 32] = {line_addr, 5'b0} + 32'(4 * i);
        return l;
    endfunction

    function automatic line_t shadow_line(input logic [26:0] line_addr);
        if (shadow.exists(line_addr))
            return shadow[line_addr];
        return initial_line(line_addr);
    endfunction

    initial
    begin
        error_count = 0;
        fills = 0;
        wbs = 0;
        cycles = 0;
    end

    always @(posedge clk)
    begin
        line_t exp_line;
        line_t merged;
        logic [31:0] got_word;
        if (rst_n)
        begin
            if (pmem_resp && pmem_read)
                fills++;
            if (pmem_resp && pmem_write)
            begin
                wbs++;
                exp_line = shadow_line(pmem_address[31:5]);
                if (pmem_wdata !== exp_line)
                begin
                    $display("Mismatch at %0t: pmem_wdata expected %h actual %h",
                             $time, exp_line, pmem_wdata);
                    error_count++;
                end
            end
            if (mem_read || mem_write)
                cycles++;
            if (mem_resp)
            begin
                exp_line = shadow_line(mem_address[31:5]);
                if (mem_read)
                begin
                    got_word = mem_rdata256[32*mem_address[4:2] +: 32];
                    if (got_word !== exp_word)
                    begin
                        $display("Mismatch at %0t: mem_rdata256 word expected %h actual %h",
                                 $time, exp_word, got_word);
                        error_count++;
                    end
                    if (mem_rdata256 !== exp_line)
                    begin
                        $display("Mismatch at %0t: mem_rdata256 expected %h actual %h",
                                 $time, exp_line, mem_rdata256);
                        error_count++;
                    end
                end
                else
                begin
                    merged = exp_line;
                    for (int i = 0; i < 32; i++)
                        if (mem_byte_enable256[i])
                            merged[8*i +: 8] = mem_wdata256[8*i +: 8];
                    shadow[mem_address[31:5]] = merged;
                end
                if (fills != exp_fills)
                begin
                    $display("Mismatch at %0t: fill count expected %0d actual %0d",
                             $time, exp_fills, fills);
                    error_count++;
                end
                if (wbs != exp_wbs)
                begin
                    $display("Mismatch at %0t: write-back count expected %0d actual %0d",
                             $time, exp_wbs, wbs);
                    error_count++;
                end
                // Hits answer in the second cycle.
                if (exp_fills == 0 && exp_wbs == 0 && cycles != 2)
                begin
                    $display("Hit at %0t answered after %0d cycles instead of 2", $time, cycles);
                    error_count++;
                end
                fills = 0;
                wbs = 0;
                cycles = 0;
            end
        end
    end

endmodule : cache_checker

/* sim/clock_gen.sv */
// Testbench clock source and power-on reset generator.
`timescale 1ns/10ps

module clock_gen #(
    parameter real period       = 4.0,
    parameter int  reset_cycles = 8
)
(
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #(period / 2.0) clk = ~clk;
    end

    initial
    begin
        rst_n <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;   // Release after the reset cycles.
    end

endmodule : clock_gen

/* source/l1_cache.sv */
// Top level of the two-way L1 cache joining controller and datapath.
`timescale 1ns/10ps

module l1_cache
(
    input  logic                clk,
    input  logic                rst_n,

    // Processor side.
    input  cache_pkg::addr_t    mem_address,
    input  logic                mem_read,
    input  logic                mem_write,
    input  cache_pkg::byte_en_t mem_byte_enable256,
    input  cache_pkg::line_t    mem_wdata256,
    output cache_pkg::line_t    mem_rdata256,
    output logic                mem_resp,

    // Memory side.
    output cache_pkg::addr_t    pmem_address,
    output logic                pmem_read,
    output logic                pmem_write,
    output cache_pkg::line_t    pmem_wdata,
    input  cache_pkg::line_t    pmem_rdata,
    input  logic                pmem_resp
);

    cache_ctrl_if ctrl_if ();

    cache_control u_control
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl_if.control),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .pmem_resp  (pmem_resp),
        .mem_resp   (mem_resp),
        .pmem_read  (pmem_read),
        .pmem_write (pmem_write)
    );

    cache_datapath u_datapath
    (
        .clk                (clk),
        .rst_n              (rst_n),
        .ctrl               (ctrl_if.datapath),
        .mem_address        (mem_address),
        .mem_byte_enable256 (mem_byte_enable256),
        .mem_wdata256       (mem_wdata256),
        .pmem_rdata         (pmem_rdata),
        .pmem_write         (pmem_write),
        .mem_rdata256       (mem_rdata256),
        .pmem_wdata         (pmem_wdata),
        .pmem_address       (pmem_address)
    );

endmodule : l1_cache

/* source/cache_control.sv */
// Cache controller FSM for tag check, write-back, fill and processor response.
`timescale 1ns/10ps

module cache_control
(
    input  logic          clk,
    input  logic          rst_n,
    cache_ctrl_if.control ctrl,
    input  logic          mem_read,
    input  logic          mem_write,
    input  logic          pmem_resp,
    output logic          mem_resp,
    output logic          pmem_read,
    output logic          pmem_write
);

    typedef enum logic [2:0]
    {
        idle,
        tag_check,
        write_back,
        fill,
        reread
    } state_t;

    state_t state;
    state_t next_state;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= idle;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state       = state;
        ctrl.read_en     = 1'b0;
        ctrl.load_tag    = 1'b0;
        ctrl.set_valid   = 1'b0;
        ctrl.set_dirty   = 1'b0;
        ctrl.clear_dirty = 1'b0;
        ctrl.load_data   = 1'b0;
        ctrl.set_lru     = 1'b0;
        ctrl.fill_sel    = 1'b0;
        mem_resp         = 1'b0;
        pmem_read        = 1'b0;
        pmem_write       = 1'b0;

        unique case (state)
            idle:
            begin
                if (mem_read || mem_write)
                begin
                    ctrl.read_en = 1'b1;
                    next_state   = tag_check;
                end
            end

            tag_check:
            begin
                if (ctrl.hit)
                begin
                    mem_resp     = 1'b1;
                    ctrl.set_lru = 1'b1;
                    if (mem_write)
                    begin
                        ctrl.load_data = 1'b1;   // Merge enabled bytes.
                        ctrl.set_dirty = 1'b1;
                    end
                    next_state = idle;
                end
                else if (ctrl.victim_dirty)
                    next_state = write_back;
                else
                    next_state = fill;
            end

            write_back:
            begin
                pmem_write = 1'b1;
                if (pmem_resp)
                    next_state = fill;
            end

            fill:
            begin
                pmem_read = 1'b1;
                if (pmem_resp)
                begin
                    ctrl.load_data   = 1'b1;
                    ctrl.fill_sel    = 1'b1;
                    ctrl.load_tag    = 1'b1;
                    ctrl.set_valid   = 1'b1;
                    ctrl.clear_dirty = 1'b1;
                    next_state       = reread;
                end
            end

            // Refresh array outputs with the new line.
            reread:
            begin
                ctrl.read_en = 1'b1;
                next_state   = tag_check;
            end

            default:
                next_state = idle;
        endcase
    end

endmodule : cache_control

/* source/cache_datapath.sv */
// Two-way cache datapath with tag compare, victim select, write merge and address mux.
`timescale 1ns/10ps

module cache_datapath
(
    input  logic                clk,
    input  logic                rst_n,
    cache_ctrl_if.datapath      ctrl,
    input  cache_pkg::addr_t    mem_address,
    input  cache_pkg::byte_en_t mem_byte_enable256,
    input  cache_pkg::line_t    mem_wdata256,
    input  cache_pkg::line_t    pmem_rdata,
    input  logic                pmem_write,
    output cache_pkg::line_t    mem_rdata256,
    output cache_pkg::line_t    pmem_wdata,
    output cache_pkg::addr_t    pmem_address
);
    import cache_pkg::*;

    tag_t     req_tag;
    index_t   req_index;

    tag_t     way_tag   [2];
    logic     way_valid [2];
    logic     way_dirty [2];
    line_t    way_line  [2];
    logic     way_hit   [2];
    byte_en_t way_we    [2];
    logic     tag_load  [2];
    logic     valid_load [2];
    logic     dirty_load [2];

    logic     lru;
    logic     write_way;
    byte_en_t write_be;
    line_t    line_in;

    assign req_tag   = mem_address[31 -: tag_bits];
    assign req_index = mem_address[offset_bits +: index_bits];

    assign ctrl.hit          = way_hit[0] | way_hit[1];
    assign ctrl.hit_way      = way_hit[1];
    assign ctrl.victim_way   = lru;   // LRU bit names the way to evict.
    assign ctrl.victim_dirty = way_dirty[lru] & way_valid[lru];

    // Store hits write the hit way, fills the victim.
    assign write_way = ctrl.fill_sel ? ctrl.victim_way : ctrl.hit_way;
    assign write_be  = ctrl.fill_sel ? {line_bytes{1'b1}} : mem_byte_enable256;
    assign line_in   = ctrl.fill_sel ? pmem_rdata : mem_wdata256;

    for (genvar w = 0; w < 2; w++)
    begin : g_way
        assign way_hit[w]    = way_valid[w] && (way_tag[w] == req_tag);
        assign way_we[w]     = (ctrl.load_data && (write_way == 1'(w))) ? write_be : '0;
        assign tag_load[w]   = ctrl.load_tag && (ctrl.victim_way == 1'(w));
        assign valid_load[w] = ctrl.set_valid && (ctrl.victim_way == 1'(w));
        assign dirty_load[w] = (ctrl.set_dirty && (ctrl.hit_way == 1'(w))) ||
                               (ctrl.clear_dirty && (ctrl.victim_way == 1'(w)));

        line_array u_line
        (
            .clk     (clk),
            .rst_n   (rst_n),
            .read_en (ctrl.read_en),
            .byte_we (way_we[w]),
            .rindex  (req_index),
            .windex  (req_index),
            .datain  (line_in),
            .dataout (way_line[w])
        );

        meta_array #(.width(tag_bits)) u_tag
        (
            .clk     (clk),
            .rst_n   (rst_n),
            .read_en (ctrl.read_en),
            .load    (tag_load[w]),
            .rindex  (req_index),
            .windex  (req_index),
            .datain  (req_tag),
            .dataout (way_tag[w])
        );

        meta_array #(.width(1)) u_valid
        (
            .clk     (clk),
            .rst_n   (rst_n),
            .read_en (ctrl.read_en),
            .load    (valid_load[w]),
            .rindex  (req_index),
            .windex  (req_index),
            .datain  (1'b1),
            .dataout (way_valid[w])
        );

        // Set on store hit, cleared on fill.
        meta_array #(.width(1)) u_dirty
        (
            .clk     (clk),
            .rst_n   (rst_n),
            .read_en (ctrl.read_en),
            .load    (dirty_load[w]),
            .rindex  (req_index),
            .windex  (req_index),
            .datain  (ctrl.set_dirty),
            .dataout (way_dirty[w])
        );
    end

    meta_array #(.width(1)) u_lru
    (
        .clk     (clk),
        .rst_n   (rst_n),
        .read_en (ctrl.read_en),
        .load    (ctrl.set_lru),
        .rindex  (req_index),
        .windex  (req_index),
        .datain  (~ctrl.hit_way),   // Point away from the used way.
        .dataout (lru)
    );

    assign mem_rdata256 = way_line[ctrl.hit_way];
    assign pmem_wdata   = way_line[ctrl.victim_way];

    // Write-back uses the victim tag, fill the request line.
    assign pmem_address = pmem_write ?
                          {way_tag[ctrl.victim_way], req_index, {offset_bits{1'b0}}} :
                          {req_tag, req_index, {offset_bits{1'b0}}};

endmodule : cache_datapath

/* source/line_array.sv */
// Per-set line storage with byte write enables, registered read and forwarding.
`timescale 1ns/10ps

module line_array
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                read_en,
    input  cache_pkg::byte_en_t byte_we,
    input  cache_pkg::index_t   rindex,
    input  cache_pkg::index_t   windex,
    input  cache_pkg::line_t    datain,
    output cache_pkg::line_t    dataout
);
    import cache_pkg::*;

    line_t data [num_sets];
    line_t merged;
    logic  write;

    assign write = |byte_we;

    // Old line with the enabled bytes replaced.
    always_comb
    begin
        merged = data[windex];
        for (int i = 0; i < line_bytes; i++)
        begin
            if (byte_we[i])
                merged[8*i +: 8] = datain[8*i +: 8];
        end
    end

    always_ff @(posedge clk)
    begin
        if (write)
            data[windex] <= merged;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            dataout <= '0;
        else if (read_en)
            dataout <= (write && (windex == rindex)) ? merged : data[rindex];
    end

endmodule : line_array

/* source/meta_array.sv */
// Per-set metadata storage with registered read and write forwarding.
`timescale 1ns/10ps

module meta_array #(
    parameter int width = 1
)
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              read_en,
    input  logic              load,
    input  cache_pkg::index_t rindex,
    input  cache_pkg::index_t windex,
    input  logic [width-1:0]  datain,
    output logic [width-1:0]  dataout
);
    import cache_pkg::*;

    logic [width-1:0] data [num_sets];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < num_sets; i++)
                data[i] <= '0;
            dataout <= '0;
        end
        else
        begin
            if (load)
                data[windex] <= datain;
            if (read_en)
                dataout <= (load && (windex == rindex)) ? datain : data[rindex];
        end
    end

endmodule : meta_array

/* source/cache_ctrl_if.sv */
// Control strobes and status flags between cache controller and datapath.
`timescale 1ns/10ps

interface cache_ctrl_if;

    logic read_en;      // Load array output registers.
    logic load_tag;
    logic set_valid;
    logic set_dirty;
    logic clear_dirty;
    logic load_data;
    logic set_lru;
    logic fill_sel;     // Memory data into the line.

    // Status from the tag compare.
    logic hit;
    logic hit_way;
    logic victim_way;
    logic victim_dirty;

    modport control
    (
        output read_en, load_tag, set_valid, set_dirty, clear_dirty,
        output load_data, set_lru, fill_sel,
        input  hit, hit_way, victim_way, victim_dirty
    );

    modport datapath
    (
        input  read_en, load_tag, set_valid, set_dirty, clear_dirty,
        input  load_data, set_lru, fill_sel,
        output hit, hit_way, victim_way, victim_dirty
    );

endinterface : cache_ctrl_if

/* source/cache_pkg.sv */
// Cache geometry constants and shared address, tag, index, line and byte-enable types.
package cache_pkg;

    // Byte offset within a line.
    localparam int offset_bits = 5;

    // Set index width.
    localparam int index_bits = 3;

    localparam int tag_bits = 32 - offset_bits - index_bits;

    localparam int num_sets = 8;

    localparam int line_bytes = 32;

    // Byte address.
    typedef logic [31:0] addr_t;

    typedef logic [tag_bits-1:0] tag_t;

    typedef logic [index_bits-1:0] index_t;

    // One cache line.
    typedef logic [8*line_bytes-1:0] line_t;

    // One enable per byte of a line.
    typedef logic [line_bytes-1:0] byte_en_t;

endpackage : cache_pkg
